// ==== hw/cpu_common.sv ====
`default_nettype none

package cpu_common;

    // Basic machine types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regaddr_t;

    // Coarse class of an instruction, used by execute to pick a datapath
    typedef enum logic [3:0] {
        OP_ALU_REG,
        OP_ALU_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_SYSTEM,
        OP_ILLEGAL
    } opclass_e;

    // ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // RV32I major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // funct7 values accepted by OP and the shift immediates
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Control word, 52 bits
    typedef struct packed {
        opclass_e opclass;
        alu_op_e  alu_op;
        logic [2:0] funct3;
        regaddr_t rd;
        logic     rd_write;
        logic     use_imm;
        word_t    imm;
        logic     illegal;
        logic     spare;
    } control_word_t;

    // Item carried from decode to execute
    typedef struct packed {
        word_t         pc;
        word_t         ir;
        control_word_t cw;
        word_t         ra;
        word_t         rb;
    } decode_payload_t;

endpackage

`default_nettype wire

// ==== hw/regfile_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface regfile_if
    import cpu_common::*;
();

    // Two read ports
    regaddr_t ra_addr;
    word_t    ra_data;
    regaddr_t rb_addr;
    word_t    rb_data;

    // Single write port
    logic     wr_enable;
    regaddr_t wr_addr;
    word_t    wr_data;

    modport stage (
        output ra_addr, rb_addr,
        output wr_enable, wr_addr, wr_data,
        input  ra_data, rb_data
    );

    modport regs (
        input  ra_addr, rb_addr,
        input  wr_enable, wr_addr, wr_data,
        output ra_data, rb_data
    );

endinterface

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder
    import cpu_common::*;
#(
    parameter int REGS = 32
) (
    input  wire word_t    ir_i,
    output control_word_t cw_o
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
regaddr_t   rd;
regaddr_t   rs1;
regaddr_t   rs2;
word_t      imm_i;
word_t      imm_s;
word_t      imm_b;
word_t      imm_u;
word_t      imm_j;

logic     legal;
logic     illegal;
logic     uses_rs1;
logic     uses_rs2;
logic     uses_rd;
opclass_e opclass;
alu_op_e  alu_op;
logic     use_imm;
word_t    imm;

// ALU operation shared by OP and OP-IMM
function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? SUB : ADD;
        3'b001:  return SLL;
        3'b010:  return SLT;
        3'b011:  return SLTU;
        3'b100:  return XOR;
        3'b101:  return alt ? SRA : SRL;
        3'b110:  return OR;
        default: return AND;
    endcase
endfunction

// Fields and immediates per format
always_comb begin
    opcode = ir_i[6:0];
    funct3 = ir_i[14:12];
    funct7 = ir_i[31:25];
    rd     = ir_i[11:7];
    rs1    = ir_i[19:15];
    rs2    = ir_i[24:20];
    imm_i  = {{20{ir_i[31]}}, ir_i[31:20]};
    imm_s  = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    imm_b  = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    imm_u  = {ir_i[31:12], 12'b0};
    imm_j  = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
end

always_comb begin
    legal    = 1'b1;
    opclass  = OP_ILLEGAL;
    alu_op   = ADD;
    use_imm  = 1'b0;
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    uses_rd  = 1'b0;
    case (opcode)
        OPC_LUI: begin
            opclass = OP_LUI;
            alu_op  = PASS_B;
            use_imm = 1'b1;
            imm     = imm_u;
            uses_rd = 1'b1;
        end
        OPC_AUIPC: begin
            opclass = OP_AUIPC;
            use_imm = 1'b1;
            imm     = imm_u;
            uses_rd = 1'b1;
        end
        OPC_JAL: begin
            opclass = OP_JAL;
            use_imm = 1'b1;
            imm     = imm_j;
            uses_rd = 1'b1;
        end
        OPC_JALR: begin
            legal    = (funct3 == 3'b000);
            opclass  = OP_JALR;
            use_imm  = 1'b1;
            imm      = imm_i;
            uses_rs1 = 1'b1;
            uses_rd  = 1'b1;
        end
        OPC_BRANCH: begin
            // funct3 010 and 011 are unassigned
            legal    = (funct3[2:1] != 2'b01);
            opclass  = OP_BRANCH;
            alu_op   = funct3[2] ? (funct3[1] ? SLTU : SLT) : SUB;
            imm      = imm_b;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
        end
        OPC_LOAD: begin
            legal    = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            opclass  = OP_LOAD;
            use_imm  = 1'b1;
            imm      = imm_i;
            uses_rs1 = 1'b1;
            uses_rd  = 1'b1;
        end
        OPC_STORE: begin
            legal    = (funct3 inside {3'b000, 3'b001, 3'b010});
            opclass  = OP_STORE;
            use_imm  = 1'b1;
            imm      = imm_s;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
        end
        OPC_OP_IMM: begin
            // Only the shifts constrain funct7
            if (funct3 == 3'b001) begin
                legal = (funct7 == F7_BASE);
            end else if (funct3 == 3'b101) begin
                legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            end
            opclass  = OP_ALU_IMM;
            alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
            use_imm  = 1'b1;
            imm      = imm_i;
            uses_rs1 = 1'b1;
            uses_rd  = 1'b1;
        end
        OPC_OP: begin
            legal    = (funct7 == F7_BASE) ||
                       ((funct7 == F7_ALT) && (funct3 inside {3'b000, 3'b101}));
            opclass  = OP_ALU_REG;
            alu_op   = alu_from_funct3(funct3, funct7[5]);
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            uses_rd  = 1'b1;
        end
        OPC_MISC_MEM, OPC_SYSTEM: begin
            opclass = OP_SYSTEM;
            imm     = imm_i;
        end
        default: legal = 1'b0;
    endcase
end

// Register fields beyond the implemented set, relevant for RV32E
assign illegal = !legal ||
                 (uses_rs1 && int'(rs1) >= REGS) ||
                 (uses_rs2 && int'(rs2) >= REGS) ||
                 (uses_rd && int'(rd) >= REGS);

always_comb begin
    cw_o        = '0;
    cw_o.funct3 = funct3;
    cw_o.rd     = rd;
    if (illegal) begin
        cw_o.opclass = OP_ILLEGAL;
        cw_o.alu_op  = ADD;
        cw_o.illegal = 1'b1;
    end else begin
        cw_o.opclass  = opclass;
        cw_o.alu_op   = alu_op;
        cw_o.use_imm  = use_imm;
        cw_o.imm      = imm;
        cw_o.rd_write = uses_rd && (rd != '0);
    end
end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file
    import cpu_common::*;
#(
    parameter int REGS = 32
) (
    input wire logic clk_i,
    regfile_if.regs  rf
);

// x0 has no storage
word_t    regs [1:REGS-1];

logic     wr_en;
regaddr_t rd_addr [2];
word_t    rd_data [2];

// Writes to x0 or beyond the array are dropped
assign wr_en = rf.wr_enable && (rf.wr_addr != '0) && (int'(rf.wr_addr) < REGS);

always_ff @(posedge clk_i) begin
    if (wr_en) begin
        regs[rf.wr_addr] <= rf.wr_data;
    end
end

assign rd_addr[0] = rf.ra_addr;
assign rd_addr[1] = rf.rb_addr;

// Both read ports, with same-cycle write forwarding
always_comb begin
    for (int p = 0; p < 2; p++) begin
        if (rd_addr[p] == '0 || int'(rd_addr[p]) >= REGS) begin
            rd_data[p] = '0;
        end else if (wr_en && rf.wr_addr == rd_addr[p]) begin
            rd_data[p] = rf.wr_data;
        end else begin
            rd_data[p] = regs[rd_addr[p]];
        end
    end
end

assign rf.ra_data = rd_data[0];
assign rf.rb_data = rd_data[1];

endmodule

`default_nettype wire

// ==== hw/bypass_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module bypass_buffer #(
    parameter type T = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // write side
    input  wire T     wr_data_i,
    input  wire logic wr_valid_i,
    output wire logic wr_ready_o,

    // read side
    output wire T     rd_data_o,
    output wire logic rd_valid_o,
    input  wire logic rd_ready_i
);

typedef enum logic [1:0] {
    EMPTY,
    ONE,
    TWO
} state_e;

state_e state_q;
state_e state_d;
logic   ready_q;
T       main_q;
T       skid_q;

logic push;
logic pop;
logic load_main_in;
logic load_main_skid;
logic load_skid;

assign push = wr_valid_i && ready_q;
assign pop  = (state_q != EMPTY) && rd_ready_i;

// Occupancy FSM
always_comb begin
    state_d        = state_q;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    case (state_q)
        EMPTY: begin
            if (push) begin
                load_main_in = 1'b1;
                state_d      = ONE;
            end
        end
        ONE: begin
            if (push && pop) begin
                load_main_in = 1'b1;
            end else if (push) begin
                // Output stalled, park the new item
                load_skid = 1'b1;
                state_d   = TWO;
            end else if (pop) begin
                state_d = EMPTY;
            end
        end
        TWO: begin
            if (pop) begin
                load_main_skid = 1'b1;
                state_d        = ONE;
            end
        end
        default: state_d = EMPTY;
    endcase
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        state_q <= EMPTY;
        ready_q <= 1'b1;
    end else begin
        state_q <= state_d;
        // Ready only depends on flops, no path from rd_ready_i
        ready_q <= (state_d != TWO);
    end
end

always_ff @(posedge clk_i) begin
    if (load_main_in) begin
        main_q <= wr_data_i;
    end else if (load_main_skid) begin
        main_q <= skid_q;
    end
    if (load_skid) begin
        skid_q <= wr_data_i;
    end
end

assign wr_ready_o = ready_q;
assign rd_valid_o = (state_q != EMPTY);
assign rd_data_o  = main_q;

endmodule

`default_nettype wire

// ==== hw/stage_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_decode
    import cpu_common::*;
#(
    parameter int REGS = 32
) (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,

    // fetch channel
    input  wire word_t         fetch_pc_i,
    input  wire word_t         fetch_ir_i,
    input  wire word_t         fetch_pc_next_i,
    input  wire logic          fetch_valid_i,
    output wire logic          fetch_ready_o,

    // writeback strobe
    input  wire logic          wb_enable_i,
    input  wire regaddr_t      wb_addr_i,
    input  wire word_t         wb_data_i,

    // decode channel
    output wire word_t         decode_pc_o,
    output wire word_t         decode_ir_o,
    output wire control_word_t decode_cw_o,
    output wire word_t         decode_ra_o,
    output wire word_t         decode_rb_o,
    output wire logic          decode_valid_o,
    input  wire logic          decode_ready_i
);

regfile_if rf ();

control_word_t   cw;
regaddr_t        rs1;
regaddr_t        rs2;
decode_payload_t in_item;
decode_payload_t out_item;

// Next pc is not part of the payload, jump targets come from pc plus imm

decoder #(
    .REGS (REGS)
) decoder (
    .ir_i (fetch_ir_i),
    .cw_o (cw)
);

// Source fields sit at the same place in every format
assign rs1 = fetch_ir_i[19:15];
assign rs2 = fetch_ir_i[24:20];

assign rf.ra_addr   = rs1;
assign rf.rb_addr   = rs2;
assign rf.wr_enable = wb_enable_i;
assign rf.wr_addr   = wb_addr_i;
assign rf.wr_data   = wb_data_i;

register_file #(
    .REGS  (REGS)
) register_file (
    .clk_i (clk_i),
    .rf    (rf.regs)
);

always_comb begin
    in_item.pc = fetch_pc_i;
    in_item.ir = fetch_ir_i;
    in_item.cw = cw;
    in_item.ra = rf.ra_data;
    in_item.rb = rf.rb_data;
end

bypass_buffer #(
    .T          (decode_payload_t)
) bypass_buffer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_data_i  (in_item),
    .wr_valid_i (fetch_valid_i),
    .wr_ready_o (fetch_ready_o),
    .rd_data_o  (out_item),
    .rd_valid_o (decode_valid_o),
    .rd_ready_i (decode_ready_i)
);

assign decode_pc_o = out_item.pc;
assign decode_ir_o = out_item.ir;
assign decode_cw_o = out_item.cw;
assign decode_ra_o = out_item.ra;
assign decode_rb_o = out_item.rb;

endmodule

`default_nettype wire

// ==== bench/stage_decode_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_decode_props
    import cpu_common::*;
(
    input wire logic          clk_i,
    input wire logic          rst_n_i,
    input wire logic          fetch_ready_i,
    input wire word_t         decode_pc_i,
    input wire word_t         decode_ir_i,
    input wire control_word_t decode_cw_i,
    input wire word_t         decode_ra_i,
    input wire word_t         decode_rb_i,
    input wire logic          decode_valid_i,
    input wire logic          decode_ready_i
);

int unsigned fail_count = 0;

logic [$bits(decode_payload_t)-1:0] payload;

assign payload = {decode_pc_i, decode_ir_i, decode_cw_i, decode_ra_i, decode_rb_i};

// Stalled output keeps valid and data
hold_while_stalled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    decode_valid_i && !decode_ready_i |=> decode_valid_i && $stable(payload)
) else begin
    fail_count++;
    $error("decode channel changed while stalled");
end

// First cycle out of reset
idle_after_reset: assert property (
    @(posedge clk_i)
    $rose(rst_n_i) |-> !decode_valid_i && fetch_ready_i
) else begin
    fail_count++;
    $error("stage not idle after reset release");
end

// Empty buffer never drops ready
ready_while_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !decode_valid_i |=> fetch_ready_i
) else begin
    fail_count++;
    $error("fetch ready dropped with the buffer empty");
end

endmodule

`default_nettype wire

// ==== bench/tb_stage_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_stage_decode
    import cpu_common::*;
();

localparam int STREAM_ITEMS   = 100;
localparam int TOTAL_ITEMS    = 400;
localparam int TIMEOUT_CYCLES = TOTAL_ITEMS * 4 + 100;

logic          clk;
logic          rst_n;
word_t         fetch_pc;
word_t         fetch_ir;
word_t         fetch_pc_next;
logic          fetch_valid;
logic          fetch_ready;
logic          wb_enable;
regaddr_t      wb_addr;
word_t         wb_data;
word_t         decode_pc;
word_t         decode_ir;
control_word_t decode_cw;
word_t         decode_ra;
word_t         decode_rb;
logic          decode_valid;
logic          decode_ready;

// Register model and expected items in fetch order
word_t           reg_model [32];
decode_payload_t exp_q [$];
int              push_cycle_q [$];
bit              timed_q [$];
int              errors;
int              checks;
int              cycle;
int              issued;
int              sent;
int              received;
bit              stream_phase;
word_t           next_pc;

stage_decode #(
    .REGS            (32)
) DUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .fetch_pc_i      (fetch_pc),
    .fetch_ir_i      (fetch_ir),
    .fetch_pc_next_i (fetch_pc_next),
    .fetch_valid_i   (fetch_valid),
    .fetch_ready_o   (fetch_ready),
    .wb_enable_i     (wb_enable),
    .wb_addr_i       (wb_addr),
    .wb_data_i       (wb_data),
    .decode_pc_o     (decode_pc),
    .decode_ir_o     (decode_ir),
    .decode_cw_o     (decode_cw),
    .decode_ra_o     (decode_ra),
    .decode_rb_o     (decode_rb),
    .decode_valid_o  (decode_valid),
    .decode_ready_i  (decode_ready)
);

bind stage_decode stage_decode_props props (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_ready_i  (fetch_ready_o),
    .decode_pc_i    (decode_pc_o),
    .decode_ir_i    (decode_ir_o),
    .decode_cw_i    (decode_cw_o),
    .decode_ra_i    (decode_ra_o),
    .decode_rb_i    (decode_rb_o),
    .decode_valid_i (decode_valid_o),
    .decode_ready_i (decode_ready_i)
);

always #4 clk = ~clk;

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Mismatch %s: got 0x%h, expected 0x%h (cycle %0d)",
                 name, actual, expected, cycle);
    end
endtask

function automatic word_t reg_pattern(input int idx);
    return (32'h9e37_79b9 * word_t'(idx + 1)) ^ (word_t'(idx) << 24);
endfunction

// Low registers are favoured so writebacks often hit the sources
function automatic regaddr_t rand_reg();
    if ($urandom_range(3) != 0) begin
        return regaddr_t'($urandom_range(7));
    end
    return regaddr_t'($urandom_range(31));
endfunction

function automatic logic [6:0] rand_funct7();
    int pick;
    pick = $urandom_range(9);
    if (pick < 5) begin
        return 7'h00;
    end else if (pick < 9) begin
        return 7'h20;
    end
    return 7'($urandom);
endfunction

function automatic word_t make_instr();
    logic [2:0] f3;
    word_t      r;
    regaddr_t   rd;
    regaddr_t   rs1;
    regaddr_t   rs2;
    f3  = 3'($urandom);
    r   = $urandom;
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    case ($urandom_range(19))
        0:          return {r[31:12], rd, 7'b0110111};
        1:          return {r[31:12], rd, 7'b0010111};
        2:          return {r[31:12], rd, 7'b1101111};
        3:          return {r[31:20], rs1, ($urandom_range(3) == 0) ? f3 : 3'b000, rd,
                            7'b1100111};
        4, 5:       return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
        6, 7:       return {r[31:20], rs1, f3, rd, 7'b0000011};
        8, 9:       return {r[31:25], rs2, rs1, f3, r[11:7], 7'b0100011};
        10, 11, 12: return {rand_funct7(), rs2, rs1, f3, rd, 7'b0010011};
        13, 14, 15: return {rand_funct7(), rs2, rs1, f3, rd, 7'b0110011};
        16, 17:     return {r[31:7], ($urandom_range(1) == 1) ? 7'b1110011 : 7'b0001111};
        default:    return r;
    endcase
endfunction

// Expected control word from the RV32I encoding rules
function automatic control_word_t ref_decode(input word_t ir);
    control_word_t cw;
    logic [6:0]    f7;
    logic [2:0]    f3;
    word_t         imm_i;
    word_t         imm_s;
    word_t         imm_b;
    word_t         imm_u;
    word_t         imm_j;
    bit            legal;
    bit            writes_rd;
    bit            alt;
    f7    = ir[31:25];
    f3    = ir[14:12];
    imm_i = 32'(signed'(ir[31:20]));
    imm_s = 32'(signed'({ir[31:25], ir[11:7]}));
    imm_b = 32'(signed'({ir[31], ir[7], ir[30:25], ir[11:8], 1'b0}));
    imm_u = {ir[31:12], 12'h000};
    imm_j = 32'(signed'({ir[31], ir[19:12], ir[20], ir[30:21], 1'b0}));
    cw        = '0;
    cw.funct3 = f3;
    cw.rd     = ir[11:7];
    cw.alu_op = ADD;
    legal     = 1'b1;
    writes_rd = 1'b0;
    alt       = 1'b0;
    case (ir[6:0])
        7'b0110111: begin
            cw.opclass = OP_LUI;
            cw.alu_op  = PASS_B;
            cw.use_imm = 1'b1;
            cw.imm     = imm_u;
            writes_rd  = 1'b1;
        end
        7'b0010111, 7'b1101111: begin
            cw.opclass = ir[3] ? OP_JAL : OP_AUIPC;
            cw.use_imm = 1'b1;
            cw.imm     = ir[3] ? imm_j : imm_u;
            writes_rd  = 1'b1;
        end
        7'b1100111: begin
            legal      = (f3 == 3'd0);
            cw.opclass = OP_JALR;
            cw.use_imm = 1'b1;
            cw.imm     = imm_i;
            writes_rd  = 1'b1;
        end
        7'b1100011: begin
            legal      = (f3 != 3'd2) && (f3 != 3'd3);
            cw.opclass = OP_BRANCH;
            cw.imm     = imm_b;
            if (f3 >= 3'd6) begin
                cw.alu_op = SLTU;
            end else if (f3 >= 3'd4) begin
                cw.alu_op = SLT;
            end else begin
                cw.alu_op = SUB;
            end
        end
        7'b0000011: begin
            legal      = (f3 != 3'd3) && (f3 < 3'd6);
            cw.opclass = OP_LOAD;
            cw.use_imm = 1'b1;
            cw.imm     = imm_i;
            writes_rd  = 1'b1;
        end
        7'b0100011: begin
            legal      = (f3 <= 3'd2);
            cw.opclass = OP_STORE;
            cw.use_imm = 1'b1;
            cw.imm     = imm_s;
        end
        7'b0010011, 7'b0110011: begin
            // Bit 5 separates OP from OP-IMM
            if (ir[5]) begin
                cw.opclass = OP_ALU_REG;
                legal      = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                alt        = (f7 == 7'h20);
            end else begin
                cw.opclass = OP_ALU_IMM;
                cw.use_imm = 1'b1;
                cw.imm     = imm_i;
                if (f3 == 3'd1) legal = (f7 == 7'h00);
                if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
                alt = (f3 == 3'd5) && (f7 == 7'h20);
            end
            case (f3)
                3'd0:    cw.alu_op = alt ? SUB : ADD;
                3'd1:    cw.alu_op = SLL;
                3'd2:    cw.alu_op = SLT;
                3'd3:    cw.alu_op = SLTU;
                3'd4:    cw.alu_op = XOR;
                3'd5:    cw.alu_op = alt ? SRA : SRL;
                3'd6:    cw.alu_op = OR;
                default: cw.alu_op = AND;
            endcase
            writes_rd = 1'b1;
        end
        7'b1110011, 7'b0001111: begin
            cw.opclass = OP_SYSTEM;
            cw.imm     = imm_i;
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        cw         = '0;
        cw.funct3  = f3;
        cw.rd      = ir[11:7];
        cw.opclass = OP_ILLEGAL;
        cw.illegal = 1'b1;
    end else begin
        cw.rd_write = writes_rd && (ir[11:7] != 5'd0);
    end
    return cw;
endfunction

// Same-cycle writeback wins over the stored value
function automatic word_t read_operand(input regaddr_t addr);
    if (addr == 5'd0) begin
        return '0;
    end else if (wb_enable && wb_addr == addr) begin
        return wb_data;
    end
    return reg_model[addr];
endfunction

task automatic record_fetch();
    decode_payload_t item;
    item.pc = fetch_pc;
    item.ir = fetch_ir;
    item.cw = ref_decode(fetch_ir);
    item.ra = read_operand(fetch_ir[19:15]);
    item.rb = read_operand(fetch_ir[24:20]);
    exp_q.push_back(item);
    push_cycle_q.push_back(cycle);
    timed_q.push_back(stream_phase);
endtask

// One clock: observe at the falling edge, drive at the rising edge
task automatic cycle_step(input int limit, input int valid_pct, input int ready_pct,
                          input int wb_pct);
    bit accepted;
    @(negedge clk);
    accepted = fetch_valid && fetch_ready;
    if (stream_phase && fetch_valid) begin
        check_value("fetch_ready_o", 32'(fetch_ready), 32'd1);
    end
    if (accepted) begin
        record_fetch();
        sent++;
    end
    if (wb_enable && wb_addr != 5'd0) begin
        reg_model[wb_addr] = wb_data;
    end
    @(posedge clk);
    if (!fetch_valid || accepted) begin
        if (issued < limit && $urandom_range(99) < valid_pct) begin
            fetch_pc      <= next_pc;
            fetch_ir      <= make_instr();
            fetch_pc_next <= next_pc + 32'd4;
            fetch_valid   <= 1'b1;
            next_pc        = next_pc + 32'd4;
            issued++;
        end else begin
            fetch_valid <= 1'b0;
        end
    end
    wb_enable    <= ($urandom_range(99) < wb_pct);
    wb_addr      <= rand_reg();
    wb_data      <= $urandom;
    decode_ready <= ($urandom_range(99) < ready_pct);
endtask

// Comparing process
always @(negedge clk) begin : compare
    decode_payload_t exp_item;
    int              pushed_at;
    bit              timed;
    if (rst_n && decode_valid && decode_ready) begin
        received++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected item on the decode channel, pc 0x%h", decode_pc);
        end else begin
            exp_item  = exp_q.pop_front();
            pushed_at = push_cycle_q.pop_front();
            timed     = timed_q.pop_front();
            check_value("decode_pc_o", decode_pc, exp_item.pc);
            check_value("decode_ir_o", decode_ir, exp_item.ir);
            check_value("opclass", 32'(decode_cw.opclass), 32'(exp_item.cw.opclass));
            check_value("alu_op", 32'(decode_cw.alu_op), 32'(exp_item.cw.alu_op));
            check_value("funct3", 32'(decode_cw.funct3), 32'(exp_item.cw.funct3));
            check_value("rd", 32'(decode_cw.rd), 32'(exp_item.cw.rd));
            check_value("rd_write", 32'(decode_cw.rd_write), 32'(exp_item.cw.rd_write));
            check_value("use_imm", 32'(decode_cw.use_imm), 32'(exp_item.cw.use_imm));
            check_value("imm", decode_cw.imm, exp_item.cw.imm);
            check_value("illegal", 32'(decode_cw.illegal), 32'(exp_item.cw.illegal));
            check_value("spare", 32'(decode_cw.spare), 32'(exp_item.cw.spare));
            check_value("decode_ra_o", decode_ra, exp_item.ra);
            check_value("decode_rb_o", decode_rb, exp_item.rb);
            if (timed) begin
                check_value("decode latency", 32'(cycle - pushed_at), 32'd1);
            end
        end
    end
end

initial begin : watchdog
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle = cycle + 1;
    end
    $display("Timeout: decode stage stalled, %0d of %0d items received after %0d cycles",
             received, TOTAL_ITEMS, cycle);
    $display("Result: FAILED");
    $finish;
end

initial begin : main
    clk           = 1'b0;
    rst_n         = 1'b0;
    fetch_pc      = '0;
    fetch_ir      = '0;
    fetch_pc_next = '0;
    fetch_valid   = 1'b0;
    wb_enable     = 1'b0;
    wb_addr       = '0;
    wb_data       = '0;
    decode_ready  = 1'b0;
    errors        = 0;
    checks        = 0;
    issued        = 0;
    sent          = 0;
    received      = 0;
    stream_phase  = 1'b0;
    next_pc       = 32'h0000_1000;
    void'($urandom(97));
    for (int i = 0; i < 32; i++) begin
        reg_model[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("decode_valid_o", 32'(decode_valid), 32'd0);
    check_value("fetch_ready_o", 32'(fetch_ready), 32'd1);

    // Known contents in every register
    for (int i = 1; i < 32; i++) begin
        @(posedge clk);
        wb_enable <= 1'b1;
        wb_addr   <= regaddr_t'(i);
        wb_data   <= reg_pattern(i);
        reg_model[i] = reg_pattern(i);
    end
    @(posedge clk);
    wb_enable    <= 1'b0;
    decode_ready <= 1'b1;

    // Back-to-back stream with the output always ready
    stream_phase = 1'b1;
    while (sent < STREAM_ITEMS) begin
        cycle_step(STREAM_ITEMS, 100, 100, 30);
    end
    while (received < sent) begin
        cycle_step(STREAM_ITEMS, 0, 100, 30);
    end
    stream_phase = 1'b0;

    // Random valid, ready and writeback traffic
    while (sent < TOTAL_ITEMS) begin
        cycle_step(TOTAL_ITEMS, 75, 60, 40);
    end
    while (received < TOTAL_ITEMS) begin
        cycle_step(TOTAL_ITEMS, 0, 100, 0);
    end

    check_value("items left in expected queue", 32'(exp_q.size()), 32'd0);
    check_value("items received", 32'(received), 32'(TOTAL_ITEMS));
    if (DUT.props.fail_count != 0) begin
        errors += DUT.props.fail_count;
        $display("Handshake assertions failed %0d times", DUT.props.fail_count);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== rv_decode.f ====
hw/cpu_common.sv
hw/regfile_if.sv
hw/decoder.sv
hw/register_file.sv
hw/bypass_buffer.sv
hw/stage_decode.sv
bench/stage_decode_props.sv
bench/tb_stage_decode.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_stage_decode
FILELIST   := rv_decode.f
BUILD_DIR  := obj_dir
LOG        := sim.log
COMMON     := --timing --assert -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 -Mdir $(BUILD_DIR) $(COMMON)
RUN_ARGS   := +verilator+error+limit+1000
FAIL_MSG   := Result: FAILED
PASS_MSG   := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
